// File: Makefile
VERILATOR ?= verilator
TOP       ?= zports_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: paging_ctrl.sv
// RAM page registers, memconf, #7FFD lock logic and opcode-fetch latch
module paging_ctrl #(
  parameter int NUM_PAGES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [15:8]                             a,
  input  logic [7:0]                              din,
  input  logic                                    xt_wr,
  input  logic                                    p7ffd_try,
  input  logic                                    opfetch,
  output logic [NUM_PAGES*zports_pkg::PAGE_W-1:0] xt_page,
  output logic [7:0]                              memconf,
  output logic                                    lock48
);

  localparam int LAST = NUM_PAGES - 1; // #7FFD always maps here

  logic [zports_pkg::PAGE_W-1:0] page [NUM_PAGES];
  logic [1:0]                    page_sel;
  logic                          page_hit;
  logic                          memconf_wr;
  logic                          p7ffd_wr;
  logic                          m1_lock;
  logic                          lock128;
  logic [zports_pkg::PAGE_W-1:0] page_7ffd;
  zports_pkg::lock_mode_e        lock_mode;

  assign lock_mode = zports_pkg::lock_mode_e'(memconf[7:6]);

  // #10..#13 share the top six bits
  assign page_sel   = a[9:8];
  assign page_hit   = xt_wr && ({a[15:10], 2'b00} == zports_pkg::XT_RAMPAGE)
                      && (int'(page_sel) < NUM_PAGES);
  assign memconf_wr = xt_wr && (a[15:8] == zports_pkg::XT_MEMCONF);

  assign p7ffd_wr = p7ffd_try && !lock48;

  // last opcode had d7 == d6
  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock <= 1'b0;
    else if (opfetch)
      m1_lock <= ~(din[7] ^ din[6]);
  end

  always_comb
  begin
    case (lock_mode)
      zports_pkg::LOCK_128:  lock128 = 1'b1;
      zports_pkg::LOCK_AUTO: lock128 = m1_lock;
      default:               lock128 = 1'b0; // none and 1024
    endcase
  end

  // page number built from the #7FFD data byte
  always_comb
  begin
    if (lock_mode == zports_pkg::LOCK_1024)
      page_7ffd = {2'b00, din[5], din[7:6], din[2:0]};
    else
      page_7ffd = {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      memconf <= zports_pkg::MEMCONF_RST;
      for (int i = 0; i < NUM_PAGES; i++)
        page[i] <= zports_pkg::PAGE_RST[i*zports_pkg::PAGE_W +: zports_pkg::PAGE_W];
    end
    else if (p7ffd_wr)
    begin
      memconf[0] <= din[4]; // rom select
      page[LAST] <= page_7ffd;
    end
    else
    begin
      if (page_hit)
        page[page_sel] <= din;
      if (memconf_wr)
        memconf <= din;
    end
  end

  // 48K lock stays set until reset; 1024 mode uses d5 as a page bit instead
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != zports_pkg::LOCK_1024))
      lock48 <= din[5];
  end

  always_comb
  begin
    for (int i = 0; i < NUM_PAGES; i++)
      xt_page[i*zports_pkg::PAGE_W +: zports_pkg::PAGE_W] = page[i];
  end

endmodule

// File: port_decoder.sv
// I/O address decode, write strobes, port hit and bus drive
module port_decoder (
  input  logic [15:0] a,
  input  logic        iowr_s,
  input  logic        iord,
  output logic        xt_wr,
  output logic        p7ffd_try,
  output logic        border_wr,
  output logic        porthit,
  output logic        dataout
);

  logic [7:0] loa;
  logic [7:0] hoa;
  logic       hit_fe;
  logic       hit_xt;
  logic       hit_fd;
  logic       fe_wr;
  logic       xt_border_wr;

  assign loa = a[7:0];
  assign hoa = a[15:8];

  assign hit_fe = (loa == zports_pkg::PORT_FE);
  assign hit_xt = (loa == zports_pkg::PORT_XT);

  // a[15] high on #FD belongs to the AY side
  assign hit_fd = (loa == zports_pkg::PORT_FD) && !a[15];

  assign porthit = hit_fe || hit_xt || hit_fd;

  // drive the data bus only on our own reads
  assign dataout = porthit && iord;

  // write strobes one clk wide like iowr_s
  assign xt_wr     = hit_xt && iowr_s;
  assign p7ffd_try = hit_fd && iowr_s; // lock rule applied in paging_ctrl
  assign fe_wr     = hit_fe && iowr_s;

  // border from #FE or #0FAF
  assign xt_border_wr = xt_wr && (hoa == zports_pkg::XT_BORDER);
  assign border_wr    = fe_wr || xt_border_wr;

endmodule

// File: port_read_mux.sv
// read data selection for #FE and #AF and the power-up status flag
module port_read_mux #(
  parameter int NUM_PAGES = 4
) (
  input  logic                                    clk,
  input  logic [15:0]                             a,
  input  logic                                    iord_s,
  input  logic [4:0]                              keys_in,
  input  logic                                    tape_read,
  input  logic [NUM_PAGES*zports_pkg::PAGE_W-1:0] xt_page,
  output logic [7:0]                              dout
);

  logic [7:0] loa;
  logic [7:0] hoa;
  logic [1:0] page_sel;
  logic       page_rd;
  logic       status_rd;

  // set at configuration only and cleared by the first status read
  logic pwr_up_src  = 1'b1;
  logic pwr_up_flag = 1'b0;

  assign loa      = a[7:0];
  assign hoa      = a[15:8];
  assign page_sel = a[9:8];
  assign page_rd  = ({hoa[7:2], 2'b00} == zports_pkg::XT_RAMPAGE)
                    && (int'(page_sel) < NUM_PAGES);

  assign status_rd = iord_s && (loa == zports_pkg::PORT_XT)
                     && (hoa == zports_pkg::XT_STATUS);

  always_ff @(posedge clk)
  begin
    if (status_rd)
    begin
      pwr_up_flag <= pwr_up_src;
      pwr_up_src  <= 1'b0;
    end
  end

  always_comb
  begin
    dout = 8'hFF; // open bus for anything unknown
    case (loa)
      zports_pkg::PORT_FE:
        dout = {1'b1, tape_read, 1'b0, keys_in};
      zports_pkg::PORT_XT:
      begin
        if (hoa == zports_pkg::XT_STATUS)
          dout = {1'b0, pwr_up_flag, 6'b000000};
        else if (page_rd)
          dout = xt_page[page_sel*zports_pkg::PAGE_W +: zports_pkg::PAGE_W];
      end
      default:
        dout = 8'hFF;
    endcase
  end

endmodule

// File: sim.f
zports_pkg.sv
port_decoder.sv
paging_ctrl.sv
sys_config_regs.sv
port_read_mux.sv
zports_top.sv
tb_clock_gen.sv
zports_checker.sv
zports_asserts.sv
zports_tb.sv

// File: sys_config_regs.sv
// sysconf, cacheconf, fmaddr and intmask registers
module sys_config_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [15:8]                   a,
  input  logic [7:0]                    din,
  input  logic                          xt_wr,
  output logic [7:0]                    sysconf,
  output logic [zports_pkg::CACHE_W-1:0] cacheconf,
  output logic [zports_pkg::FMADDR_W-1:0] fmaddr,
  output logic [7:0]                    intmask
);

  logic sysconf_wr;
  logic cacheconf_wr;
  logic fmaddr_wr;
  logic intmask_wr;

  assign sysconf_wr   = xt_wr && (a[15:8] == zports_pkg::XT_SYSCONF);
  assign cacheconf_wr = xt_wr && (a[15:8] == zports_pkg::XT_CACHECONF);
  assign fmaddr_wr    = xt_wr && (a[15:8] == zports_pkg::XT_FMADDR);
  assign intmask_wr   = xt_wr && (a[15:8] == zports_pkg::XT_INTMASK);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sysconf   <= zports_pkg::SYSCONF_RST;
      cacheconf <= '0;                    // cache off
      intmask   <= zports_pkg::INTMASK_RST;
      fmaddr[4] <= 1'b0;                  // fm window closed and address bits kept
    end
    else
    begin
      if (sysconf_wr)
      begin
        sysconf   <= din;
        cacheconf <= {zports_pkg::CACHE_W{din[2]}}; // cache follows turbo bit
      end
      if (cacheconf_wr)
        cacheconf <= din[zports_pkg::CACHE_W-1:0];
      if (fmaddr_wr)
        fmaddr <= din[zports_pkg::FMADDR_W-1:0];
      if (intmask_wr)
        intmask <= din;
    end
  end

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset generator with reset repeated on request
module tb_clock_gen #(
  parameter int RST_CYCLES = 8
) (
  input  logic reset_req,
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial
  begin
    rst = 1'b1;
    forever
    begin
      repeat (RST_CYCLES) @(posedge clk);
      #2 rst = 1'b0; // released in step with the stimulus
      @(posedge reset_req);
      rst = 1'b1;
    end
  end

endmodule

// File: zports_asserts.sv
// concurrent checks on port decode and #7FFD lock rules bound into the RTL top level
module zports_asserts #(
  parameter int PAGE_BITS = zports_pkg::NUM_PAGES * zports_pkg::PAGE_W
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 porthit,
  input logic                 dataout,
  input logic                 p7ffd_try,
  input logic                 lock48,
  input logic [PAGE_BITS-1:0] xt_page
);
  timeunit 1ns;
  timeprecision 100ps;

  // bus is driven only on our own ports
  dataout_needs_hit: assert property (@(posedge clk) disable iff (rst) dataout |-> porthit)
    else $error("dataout high while no port is hit");

  // locked #7FFD attempt leaves every page alone
  locked_pages_hold: assert property (@(posedge clk) disable iff (rst)
    (p7ffd_try && lock48) |=> $stable(xt_page))
    else $error("page changed on a #7FFD write while the 48K lock was set");

endmodule

bind zports_top zports_asserts zports_asserts_inst (
  .clk       (clk),
  .rst       (rst),
  .porthit   (porthit),
  .dataout   (dataout),
  .p7ffd_try (p7ffd_try),
  .lock48    (lock48),
  .xt_page   (xt_page)
);

// File: zports_checker.sv
// reference model of the port block, per-cycle comparison and error counts
module zports_checker #(
  parameter int NUM_PAGES = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [3:0]             test_id,
  input  logic [15:0]            a,
  input  logic [7:0]             din,
  input  logic                   iowr_s,
  input  logic                   iord_s,
  input  logic                   iord,
  input  logic                   opfetch,
  input  logic [4:0]             keys_in,
  input  logic                   tape_read,
  input  logic [7:0]             dout,
  input  logic                   porthit,
  input  logic                   dataout,
  input  logic                   border_wr,
  input  logic [NUM_PAGES*8-1:0] xt_page,
  input  logic [7:0]             memconf,
  input  logic [7:0]             sysconf,
  input  logic [3:0]             cacheconf,
  input  logic [4:0]             fmaddr,
  input  logic [7:0]             intmask,
  input  logic                   lock48,
  output int                     errors,
  output int                     checks
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] m_page [NUM_PAGES];
  logic [7:0] m_memconf;
  logic [7:0] m_sysconf;
  logic [7:0] m_intmask;
  logic [3:0] m_cache;
  logic [4:0] m_fmaddr;
  logic       fm_known = 1'b0; // low fmaddr bits undefined until written
  logic       m_lock48;
  logic       m_m1;
  logic       m_pwr_src = 1'b1;
  logic       m_pwr_flag = 1'b0;
  int         err_cnt = 0;
  int         chk_cnt = 0;

  assign errors = err_cnt;
  assign checks = chk_cnt;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_values";
      4'd2:    return "xt_writes";
      4'd3:    return "p7ffd_modes";
      4'd4:    return "lock48";
      4'd5:    return "port_reads";
      default: return "idle";
    endcase
  endfunction

  // last page after an accepted #7FFD write
  function automatic logic [7:0] ref_7ffd_page(input logic [1:0] mode, input logic m1,
                                               input logic [7:0] d);
    case (mode)
      zports_pkg::LOCK_128:  return {5'b00000, d[2:0]};
      zports_pkg::LOCK_AUTO: return m1 ? {5'b00000, d[2:0]} : {3'b000, d[7:6], d[2:0]};
      zports_pkg::LOCK_1024: return {2'b00, d[5], d[7:6], d[2:0]};
      default:               return {3'b000, d[7:6], d[2:0]};
    endcase
  endfunction

  function automatic logic [7:0] ref_dout(input logic [15:0] ad);
    if (ad[7:0] == zports_pkg::PORT_FE)
      return {1'b1, tape_read, 1'b0, keys_in};
    if (ad[7:0] != zports_pkg::PORT_XT)
      return 8'hFF;
    if (ad[15:8] == zports_pkg::XT_STATUS)
      return {1'b0, m_pwr_flag, 6'b000000};
    if (ad[15:10] == 6'b000100 && int'(ad[9:8]) < NUM_PAGES)
      return m_page[ad[9:8]];
    return 8'hFF;
  endfunction

  function automatic logic ref_hit(input logic [15:0] ad);
    return (ad[7:0] == zports_pkg::PORT_FE) || (ad[7:0] == zports_pkg::PORT_XT)
           || (ad[7:0] == zports_pkg::PORT_FD && !ad[15]);
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name(test_id), what, exp, act);
    end
  endtask

  task automatic model_xt_write(input logic [7:0] hi, input logic [7:0] d);
    if (hi[7:2] == 6'b000100 && int'(hi[1:0]) < NUM_PAGES)
      m_page[hi[1:0]] = d;
    if (hi == zports_pkg::XT_FMADDR)
    begin
      m_fmaddr = d[4:0];
      fm_known = 1'b1;
    end
    if (hi == zports_pkg::XT_SYSCONF)
    begin
      m_sysconf = d;
      m_cache   = {4{d[2]}}; // cache bits copy the turbo bit
    end
    if (hi == zports_pkg::XT_MEMCONF)
      m_memconf = d;
    if (hi == zports_pkg::XT_INTMASK)
      m_intmask = d;
    if (hi == zports_pkg::XT_CACHECONF)
      m_cache = d[3:0];
  endtask

  // model state advances on the same edge as the DUT
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_PAGES; i++)
        m_page[i] = zports_pkg::PAGE_RST[i*8 +: 8];
      m_memconf   = 8'h04;
      m_sysconf   = 8'h00;
      m_intmask   = 8'h01;
      m_cache     = 4'h0;
      m_fmaddr[4] = 1'b0;
      m_lock48    = 1'b0;
      m_m1        = 1'b0;
    end
    else
    begin
      if (iowr_s && a[7:0] == zports_pkg::PORT_FD && !a[15] && !m_lock48)
      begin
        m_page[NUM_PAGES-1] = ref_7ffd_page(m_memconf[7:6], m_m1, din);
        if (m_memconf[7:6] != zports_pkg::LOCK_1024)
          m_lock48 = din[5];
        m_memconf[0] = din[4];
      end
      else if (iowr_s && a[7:0] == zports_pkg::PORT_XT)
        model_xt_write(a[15:8], din);
      if (opfetch)
        m_m1 = (din[7] == din[6]); // old value already used above
    end
    if (iord_s && a == 16'h00AF)
    begin
      m_pwr_flag = m_pwr_src;
      m_pwr_src  = 1'b0;
    end
  end

  // outputs settled by mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int i = 0; i < NUM_PAGES; i++)
        compare($sformatf("page%0d", i), 32'(m_page[i]), 32'(xt_page[i*8 +: 8]));
      compare("memconf", 32'(m_memconf), 32'(memconf));
      compare("sysconf", 32'(m_sysconf), 32'(sysconf));
      compare("cacheconf", 32'(m_cache), 32'(cacheconf));
      compare("intmask", 32'(m_intmask), 32'(intmask));
      compare("lock48", 32'(m_lock48), 32'(lock48));
      compare("dout", 32'(ref_dout(a)), 32'(dout));
      compare("porthit", 32'(ref_hit(a)), 32'(porthit));
      compare("dataout", 32'(ref_hit(a) && iord), 32'(dataout));
      compare("border_wr", 32'(iowr_s && (a[7:0] == 8'hFE || a == 16'h0FAF)),
              32'(border_wr));
      if (fm_known)
        compare("fmaddr", 32'(m_fmaddr), 32'(fmaddr));
    end
  end

endmodule

// File: zports_pkg.sv
// port codes, extended register codes, lock modes, widths and reset values
package zports_pkg;

  // low address byte of the ports handled here
  typedef enum logic [7:0] {
    PORT_FE = 8'hFE, // keyboard, tape, border
    PORT_FD = 8'hFD, // 128K paging when a[15] is low
    PORT_XT = 8'hAF  // extended config, register in high byte
  } port_e;

  // high address byte of a #xxAF access
  typedef enum logic [7:0] {
    XT_STATUS    = 8'h00,
    XT_BORDER    = 8'h0F,
    XT_RAMPAGE   = 8'h10, // #10..#13, page number in bits 1:0
    XT_FMADDR    = 8'h15,
    XT_SYSCONF   = 8'h20,
    XT_MEMCONF   = 8'h21,
    XT_INTMASK   = 8'h2A,
    XT_CACHECONF = 8'h2B
  } xt_reg_e;

  // #7FFD lock behaviour, taken from memconf[7:6]
  typedef enum logic [1:0] {
    LOCK_NONE = 2'b00, // full 512K through din[7:6]
    LOCK_128  = 2'b01, // plain 128K
    LOCK_AUTO = 2'b10, // 128K only when the last opcode had d7 == d6
    LOCK_1024 = 2'b11  // d5 used as page bit, no 48K lock
  } lock_mode_e;

  // register widths
  localparam int PAGE_W    = 8;
  localparam int NUM_PAGES = 4;
  localparam int FMADDR_W  = 5;
  localparam int CACHE_W   = 4;

  // reset values
  localparam logic [7:0] MEMCONF_RST = 8'h04; // rom mapping off
  localparam logic [7:0] SYSCONF_RST = 8'h00; // 3.5 MHz
  localparam logic [7:0] INTMASK_RST = 8'h01; // frame int only

  // pages 3..0, page 0 in the low byte
  localparam logic [NUM_PAGES*PAGE_W-1:0] PAGE_RST = {
    8'h00, // page 3
    8'h02, // page 2
    8'h05, // page 1
    8'h00  // page 0
  };

endpackage

// File: zports_tb.sv
// testbench top with clock, DUT, checker, LFSR stimulus, timeout and final result
module zports_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PAGES  = 4;
  localparam int RST_CYCLES = 8;
  localparam int N_XT       = 48; // random extended writes
  localparam int N_RD       = 8;  // random reads of each kind
  localparam int TEST_CYCLES = RST_CYCLES + 2 + 3 * N_XT + 4 * 10
                               + (RST_CYCLES + 10) + (4 * N_RD + 20) + 2;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

  logic                   clk, rst, reset_req;
  logic [3:0]             test_id;
  logic [15:0]            a;
  logic [7:0]             din;
  logic                   iowr_s, iord_s, iord, opfetch;
  logic [4:0]             keys_in;
  logic                   tape_read;
  logic [7:0]             dout, memconf, sysconf, intmask;
  logic                   porthit, dataout, border_wr, lock48;
  logic [NUM_PAGES*8-1:0] xt_page;
  logic [3:0]             cacheconf;
  logic [4:0]             fmaddr;
  logic [31:0]            lfsr_state = 32'h3573;
  int                     errors, checks, cycles;

  tb_clock_gen #(.RST_CYCLES(RST_CYCLES)) clock_gen_inst (
    .reset_req (reset_req),
    .clk       (clk),
    .rst       (rst)
  );

  zports_top #(.NUM_PAGES(NUM_PAGES)) zports_top_inst (.*);

  zports_checker #(.NUM_PAGES(NUM_PAGES)) checker_inst (.*);

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [7:0] xt_target(input int idx);
    case (idx)
      0, 1, 2, 3: return 8'h10 + idx[7:0]; // page registers
      4:          return zports_pkg::XT_FMADDR;
      5:          return zports_pkg::XT_SYSCONF;
      6:          return zports_pkg::XT_MEMCONF;
      7:          return zports_pkg::XT_INTMASK;
      default:    return zports_pkg::XT_CACHECONF;
    endcase
  endfunction

  // d7 set so the lock modes differ, d5 only where it cannot lock
  function automatic logic [7:0] paging_data(input int mode, input logic [7:0] rnd);
    if (mode == 3)
      return rnd | 8'hA0;
    return (rnd & 8'hDF) | 8'h80;
  endfunction

  // each task starts 2 ns after a rising edge and ends there
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    a = addr;
    din = data;
    iowr_s = 1'b1;
    @(posedge clk);
    #2 iowr_s = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr);
    a = addr;
    iord = 1'b1;
    iord_s = 1'b1;
    @(posedge clk);
    #2 iord_s = 1'b0;
    @(posedge clk);
    #2 iord = 1'b0;
  endtask

  task automatic fetch(input logic [7:0] op);
    din = op;
    opfetch = 1'b1;
    @(posedge clk);
    #2 opfetch = 1'b0;
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    logic [31:0] r;
    logic [7:0]  code;
    a = '0;
    din = '0;
    iowr_s = 1'b0;
    iord_s = 1'b0;
    iord = 1'b0;
    opfetch = 1'b0;
    keys_in = '0;
    tape_read = 1'b0;
    reset_req = 1'b0;
    test_id = 4'd0;
    @(negedge rst);
    test_id = 4'd1;
    repeat (2) @(posedge clk);
    #2;
    test_id = 4'd2;
    for (int i = 0; i < N_XT; i++)
    begin
      code = xt_target(i % 9); // every register in turn
      take_bits(8, r);
      bus_write({code, 8'hAF}, r[7:0]);
      if (code[7:2] == 6'b000100)
        bus_read({code, 8'hAF});
    end
    test_id = 4'd3;
    for (int mode = 0; mode < 4; mode++)
    begin
      bus_write({zports_pkg::XT_MEMCONF, 8'hAF}, {mode[1:0], 6'b000100});
      fetch(8'hC9); // d7 == d6
      take_bits(8, r);
      bus_write(16'h7FFD, paging_data(mode, r[7:0]));
      bus_read(16'h13AF);
      fetch(8'h80); // d7 != d6
      take_bits(8, r);
      bus_write(16'h7FFD, paging_data(mode, r[7:0]));
      bus_read(16'h13AF);
      take_bits(8, r);
      bus_write(16'hFFFD, r[7:0]); // a[15] set so this is the AY port
    end
    test_id = 4'd4;
    bus_write(16'h21AF, 8'h44);
    bus_write(16'h7FFD, 8'h27); // d5 sets the 48K lock
    for (int i = 0; i < 4; i++)
    begin
      take_bits(8, r);
      bus_write(16'h7FFD, r[7:0]);
    end
    reset_req = 1'b1;
    @(negedge rst);
    reset_req = 1'b0;
    bus_write(16'h7FFD, 8'h03);
    bus_read(16'h13AF);
    test_id = 4'd5;
    bus_read(16'h00AF);
    bus_read(16'h00AF);
    for (int i = 0; i < N_RD; i++)
    begin
      take_bits(6, r);
      keys_in = r[4:0];
      tape_read = r[5];
      take_bits(8, r);
      bus_read({r[7:0], 8'hFE});
    end
    for (int i = 0; i < N_RD; i++)
    begin
      take_bits(16, r);
      if (r[7:0] == 8'hFE || r[7:0] == 8'hFD || r[7:0] == 8'hAF)
        r[0] = ~r[0]; // keep clear of handled ports
      bus_read(r[15:0]);
    end
    bus_read(16'h7FFD);
    bus_read(16'hFFFD);
    bus_read(16'h0FAF);
    bus_read(16'h15AF);
    bus_read(16'h20AF);
    bus_read(16'h30AF);
    bus_read(16'h14AF);
    bus_write(16'h00FE, 8'h05);
    bus_write(16'h0FAF, 8'h02);
    test_id = 4'd0;
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: zports_top.sv
// system port block top level with decoder, paging, config registers and read mux
module zports_top #(
  parameter int NUM_PAGES = zports_pkg::NUM_PAGES
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [15:0]                             a,
  input  logic [7:0]                              din,
  input  logic                                    iowr_s,
  input  logic                                    iord_s,
  input  logic                                    iord,
  input  logic                                    opfetch,
  input  logic [4:0]                              keys_in,
  input  logic                                    tape_read,
  output logic [7:0]                              dout,
  output logic                                    porthit,
  output logic                                    dataout,
  output logic                                    border_wr,
  output logic [NUM_PAGES*zports_pkg::PAGE_W-1:0] xt_page,
  output logic [7:0]                              memconf,
  output logic [7:0]                              sysconf,
  output logic [zports_pkg::CACHE_W-1:0]          cacheconf,
  output logic [zports_pkg::FMADDR_W-1:0]         fmaddr,
  output logic [7:0]                              intmask,
  output logic                                    lock48
);

  logic xt_wr;     // any #xxAF write
  logic p7ffd_try; // #7FFD write before the lock check

  port_decoder port_decoder_inst (
    .a         (a),
    .iowr_s    (iowr_s),
    .iord      (iord),
    .xt_wr     (xt_wr),
    .p7ffd_try (p7ffd_try),
    .border_wr (border_wr),
    .porthit   (porthit),
    .dataout   (dataout)
  );

  paging_ctrl #(
    .NUM_PAGES (NUM_PAGES)
  ) paging_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .a         (a[15:8]),
    .din       (din),
    .xt_wr     (xt_wr),
    .p7ffd_try (p7ffd_try),
    .opfetch   (opfetch),
    .xt_page   (xt_page),
    .memconf   (memconf),
    .lock48    (lock48)
  );

  sys_config_regs sys_config_regs_inst (
    .clk       (clk),
    .rst       (rst),
    .a         (a[15:8]),
    .din       (din),
    .xt_wr     (xt_wr),
    .sysconf   (sysconf),
    .cacheconf (cacheconf),
    .fmaddr    (fmaddr),
    .intmask   (intmask)
  );

  port_read_mux #(
    .NUM_PAGES (NUM_PAGES)
  ) port_read_mux_inst (
    .clk       (clk),
    .a         (a),
    .iord_s    (iord_s),
    .keys_in   (keys_in),
    .tape_read (tape_read),
    .xt_page   (xt_page),
    .dout      (dout)
  );

endmodule
